//--- Bender.yml
package:
  name: mem_unit

sources:
  - files:
      - hdl/mem_pkg.sv
      - hdl/spram.sv
      - hdl/cmd_decode.sv
      - hdl/mem_execute.sv
      - hdl/rsp_result.sv
      - hdl/mem_unit_top.sv
  - target: simulation
    files:
      - sim/tb_mem_unit.sv

//--- hdl/cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_decode (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          cmd_valid,  // one-cycle strobe from requester
    input  wire mem_pkg::cmd_t cmd,
    input  wire logic          busy,       // from top, blocks acceptance
    output logic               dec_valid,  // one-cycle pulse to execute
    output mem_pkg::dec_t      dec
);

    logic          accept;
    mem_pkg::dec_t dec_d;

    assign accept = cmd_valid & ~busy;

    // opcode -> ram write shape
    // set/clear become plain masked writes, so no read is needed for them
    always_comb begin
        dec_d              = '0;
        dec_d.addr         = cmd.addr;
        dec_d.tag          = cmd.tag;
        dec_d.operand      = cmd.operand;
        case (cmd.op)
            mem_pkg::op_read: begin
                dec_d.is_read = 1'b1;  // wdata/wmask stay zero
            end
            mem_pkg::op_write: begin
                dec_d.wdata    = cmd.operand;
                dec_d.wmask    = cmd.mask;
                dec_d.is_write = 1'b1;
            end
            mem_pkg::op_set: begin
                dec_d.wdata    = '1;           // ones where operand selects
                dec_d.wmask    = cmd.operand;
                dec_d.is_write = 1'b1;
            end
            mem_pkg::op_clear: begin
                dec_d.wdata    = '0;           // zeros where operand selects
                dec_d.wmask    = cmd.operand;
                dec_d.is_write = 1'b1;
            end
            mem_pkg::op_fetch_add: begin
                dec_d.wmask        = '1;       // sum goes back whole
                dec_d.is_fetch_add = 1'b1;
            end
            default: begin
                dec_d.is_illegal = 1'b1;       // codes 5..7, no ram access
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= accept;
        end
    end

    // payload only, loads on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            dec <= dec_d;
        end
    end

    // requester has to honour busy, a strobe during busy is dropped
    no_cmd_while_busy_a: assert property (
        @(posedge clk) disable iff (!rst_n) busy |-> !cmd_valid
    ) else $error("cmd_decode: cmd_valid raised while busy");

endmodule

`default_nettype wire

//--- hdl/mem_execute.sv
`timescale 1ns/1ps
`default_nettype none

module mem_execute (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          dec_valid,
    input  wire mem_pkg::dec_t dec,
    input  wire mem_pkg::data_t dout,    // ram read data
    output logic               ce,
    output logic               we,
    output mem_pkg::data_t     wmask,
    output mem_pkg::data_t     din,
    output mem_pkg::addr_t     addr,
    output logic               done,       // one-cycle pulse to result stage
    output logic               rd_capture, // rdata carries a read result
    output logic               err,
    output mem_pkg::tag_t      tag,
    output mem_pkg::data_t     rdata,      // dout or held old word
    output logic               active      // command in flight here
);

    mem_pkg::exe_state_e state_q;
    mem_pkg::exe_state_e state_d;
    mem_pkg::dec_t       dec_q;   // held copy for the later cycles
    mem_pkg::data_t      old_q;   // pre-add word of fetch-and-add

    always_comb begin
        state_d = state_q;
        case (state_q)
            mem_pkg::idle: begin
                if (dec_valid) begin
                    state_d = dec.is_fetch_add ? mem_pkg::fa_read : mem_pkg::access;
                end
            end
            mem_pkg::access:   state_d = mem_pkg::idle;
            mem_pkg::fa_read:  state_d = mem_pkg::fa_write;
            mem_pkg::fa_write: state_d = mem_pkg::idle;
            default:           state_d = mem_pkg::idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= mem_pkg::idle;
        end else begin
            state_q <= state_d;
        end
    end

    // addr/tag/flags held from dec_valid to done
    always_ff @(posedge clk) begin
        if (state_q == mem_pkg::idle && dec_valid) begin
            dec_q <= dec;
        end
        if (state_q == mem_pkg::fa_read) begin
            old_q <= dout;  // dout valid here from the cycle-1 read
        end
    end

    // ram drive
    // first access goes straight from dec in the dec_valid cycle
    always_comb begin
        ce    = 1'b0;
        we    = 1'b0;
        addr  = dec_q.addr;
        wmask = dec_q.wmask;
        din   = dec_q.wdata;
        case (state_q)
            mem_pkg::idle: begin
                addr  = dec.addr;
                wmask = dec.wmask;
                din   = dec.wdata;
                ce    = dec_valid & ~dec.is_illegal;  // fa issues its read here
                we    = dec_valid & dec.is_write;
            end
            mem_pkg::fa_read: begin
                ce  = 1'b1;
                we  = 1'b1;
                din = dout + dec_q.operand;  // wraps mod 2^32, wmask is all ones
            end
            default: begin
            end
        endcase
    end

    assign done       = (state_q == mem_pkg::access) || (state_q == mem_pkg::fa_write);
    assign rd_capture = (state_q == mem_pkg::access && dec_q.is_read) ||
                        (state_q == mem_pkg::fa_write);
    assign err        = done & dec_q.is_illegal;
    assign tag        = dec_q.tag;
    assign rdata      = (state_q == mem_pkg::fa_write) ? old_q : dout;
    assign active     = dec_valid || (state_q != mem_pkg::idle);

    done_pulse_a: assert property (
        @(posedge clk) disable iff (!rst_n) done |=> !done
    ) else $error("mem_execute: done held longer than one cycle");

    // in idle only a fresh decoded command may write
    no_idle_write_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_q == mem_pkg::idle && !dec_valid) |-> !we
    ) else $error("mem_execute: we high in idle with no command");

endmodule

`default_nettype wire

//--- hdl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int data_w = 32;           // ram word width
    localparam int addr_w = 8;            // word address width
    localparam int tag_w  = 4;            // requester label width
    localparam int depth  = 1 << addr_w;  // 256 words

    typedef logic [data_w-1:0] data_t;    // words, operands, masks
    typedef logic [addr_w-1:0] addr_t;
    typedef logic [tag_w-1:0]  tag_t;

    // codes 5..7 are not listed and decode as illegal
    typedef enum logic [2:0] {
        op_read      = 3'd0,  // plain read
        op_write     = 3'd1,  // operand under mask
        op_set       = 3'd2,  // set bits where operand is one
        op_clear     = 3'd3,  // clear bits where operand is one
        op_fetch_add = 3'd4   // old word back, old + operand stored
    } op_e;

    typedef struct packed {
        op_e   op;
        addr_t addr;
        data_t operand;
        data_t mask;            // only looked at by op_write
        tag_t  tag;
    } cmd_t;

    typedef struct packed {
        addr_t addr;
        data_t wdata;           // ram write data, already shaped by opcode
        data_t wmask;           // per-bit ram write mask
        tag_t  tag;
        data_t operand;         // kept for the fetch-and-add sum
        logic  is_write;
        logic  is_read;
        logic  is_fetch_add;
        logic  is_illegal;
    } dec_t;

    typedef struct packed {
        tag_t  tag;
        data_t rdata;
        logic  err;
    } rsp_t;

    typedef enum logic [1:0] {
        idle,      // waiting for dec_valid, single access issued from here
        access,    // single-access result cycle, done
        fa_read,   // old word on dout, sum written
        fa_write   // sum landed, done
    } exe_state_e;

endpackage

`default_nettype wire

//--- hdl/mem_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_unit_top (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          cmd_valid,
    input  wire mem_pkg::cmd_t cmd,
    output logic               busy,       // one command in flight
    output logic               rsp_valid,
    output mem_pkg::rsp_t      rsp
);

    logic           dec_valid;
    mem_pkg::dec_t  dec;
    logic           ce;
    logic           we;
    mem_pkg::data_t wmask;
    mem_pkg::data_t din;
    mem_pkg::addr_t addr;
    mem_pkg::data_t dout;
    logic           done;
    logic           rd_capture;
    logic           err;
    mem_pkg::tag_t  tag;
    mem_pkg::data_t rdata;
    logic           active;

    // set on acceptance, dropped on the response edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (rsp_valid) begin
            busy <= 1'b0;
        end else if (cmd_valid && !busy) begin
            busy <= 1'b1;
        end
    end

    cmd_decode decode_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    mem_execute execute_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .dec_valid  (dec_valid),
        .dec        (dec),
        .dout       (dout),
        .ce         (ce),
        .we         (we),
        .wmask      (wmask),
        .din        (din),
        .addr       (addr),
        .done       (done),
        .rd_capture (rd_capture),
        .err        (err),
        .tag        (tag),
        .rdata      (rdata),
        .active     (active)
    );

    spram ram_i (
        .clk   (clk),
        .ce    (ce),
        .we    (we),
        .wmask (wmask),
        .addr  (addr),
        .din   (din),
        .dout  (dout)
    );

    rsp_result result_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .done       (done),
        .rd_capture (rd_capture),
        .err        (err),
        .tag        (tag),
        .rdata_in   (rdata),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

    // execute must never run outside the busy window
    active_in_busy_a: assert property (
        @(posedge clk) disable iff (!rst_n) active |-> busy
    ) else $error("mem_unit_top: execute active while busy low");

endmodule

`default_nettype wire

//--- hdl/rsp_result.sv
`timescale 1ns/1ps
`default_nettype none

module rsp_result (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           done,        // execute finished a command
    input  wire logic           rd_capture,  // rdata_in is meaningful
    input  wire logic           err,
    input  wire mem_pkg::tag_t  tag,
    input  wire mem_pkg::data_t rdata_in,
    output logic                rsp_valid,   // one-cycle pulse, no back-pressure
    output mem_pkg::rsp_t       rsp
);

    mem_pkg::rsp_t rsp_d;

    // writes and illegal ops report zero data
    always_comb begin
        rsp_d.tag   = tag;
        rsp_d.err   = err;
        rsp_d.rdata = rd_capture ? rdata_in : '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= done;  // done is a pulse, so is this
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            rsp <= rsp_d;  // held until the next response
        end
    end

endmodule

`default_nettype wire

//--- hdl/spram.sv
`timescale 1ns/1ps
`default_nettype none

module spram (
    input  wire logic          clk,
    input  wire logic          ce,     // chip enable
    input  wire logic          we,     // write enable, qualified by ce
    input  wire mem_pkg::data_t wmask, // per-bit write mask
    input  wire mem_pkg::addr_t addr,
    input  wire mem_pkg::data_t din,
    output mem_pkg::data_t     dout    // registered read port
);

    mem_pkg::data_t mem [mem_pkg::depth];  // no reset, contents undefined at start

    // masked write, bits outside wmask keep their old value
    always_ff @(posedge clk) begin
        if (ce && we) begin
            mem[addr] <= (din & wmask) | (mem[addr] & ~wmask);
        end
    end

    // read happens on every enabled edge, writes included
    // dout sees the word as it was before this edge's write
    always_ff @(posedge clk) begin
        if (ce) begin
            dout <= mem[addr];
        end
    end

    // an unknown address would smear the whole array in simulation
    addr_known_a: assert property (
        @(posedge clk) ce |-> !$isunknown(addr)
    ) else $error("spram: addr unknown while ce high");

endmodule

`default_nettype wire

//--- sim/tb_mem_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_unit;

    localparam int n_init     = mem_pkg::depth;             // one full-mask write per word
    localparam int n_rand     = 300;
    localparam int max_cycles = (n_init + n_rand) * 8 + 100; // about 6 cycles per command plus margin

    typedef struct packed {
        mem_pkg::rsp_t rsp;
        logic [2:0]    lat;  // cycles from acceptance edge to rsp_valid
    } exp_t;

    logic           clk;
    logic           rst_n;
    logic           cmd_valid;
    mem_pkg::cmd_t  cmd;
    logic           busy;
    logic           rsp_valid;
    mem_pkg::rsp_t  rsp;

    logic           accept;
    logic           pending;    // accepted and not yet answered
    int             since;      // edges since last acceptance
    int             rsp_count;
    int             cyc;
    exp_t           exp_cur;    // expectation for the command in flight
    exp_t           exp_q[$];
    mem_pkg::data_t model_mem [mem_pkg::depth];

    mem_unit_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    always #4 clk = ~clk;  // 8 ns period

    assign accept = cmd_valid && !busy;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] got);
        stop_run($sformatf("FAIL t=%0t %s expected %h got %h", $time, name, exp, got));
    endtask

    // reference updated at send time since only one command is in flight
    task automatic send_cmd(input mem_pkg::cmd_t c);
        exp_t           e;
        mem_pkg::data_t word;
        e         = '0;
        word      = model_mem[c.addr];
        e.rsp.tag = c.tag;
        e.lat     = 3'd3;
        case (c.op)
            mem_pkg::op_read:  e.rsp.rdata = word;
            mem_pkg::op_write: model_mem[c.addr] = (c.operand & c.mask) | (word & ~c.mask);
            mem_pkg::op_set:   model_mem[c.addr] = word | c.operand;
            mem_pkg::op_clear: model_mem[c.addr] = word & ~c.operand;
            mem_pkg::op_fetch_add: begin
                e.rsp.rdata       = word;              // pre-add word comes back
                e.lat             = 3'd4;
                model_mem[c.addr] = word + c.operand;  // wraps at 32 bits
            end
            default: e.rsp.err = 1'b1;  // codes 5..7 leave memory alone
        endcase
        exp_q.push_back(e);
        cmd       <= c;
        cmd_valid <= 1'b1;
        @(posedge clk);
        cmd_valid <= 1'b0;  // one-cycle strobe
        do begin
            @(posedge clk);
        end while (busy);
    endtask

    // acceptance and response bookkeeping
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending   <= 1'b0;
            since     <= 0;
            rsp_count <= 0;
        end else begin
            since <= since + 1;
            if (accept) begin
                pending <= 1'b1;
                since   <= 1;
                if (exp_q.size() == 0) begin
                    stop_run("DUT accepted a command that was never sent");
                end else begin
                    exp_cur <= exp_q.pop_front();
                end
            end
            if (rsp_valid) begin
                pending   <= 1'b0;
                rsp_count <= rsp_count + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (cyc >= max_cycles) begin
            stop_run("timeout: the command stream did not finish in time");
        end else begin
            cyc <= cyc + 1;
        end
    end

    reset_quiet_a: assert property (@(posedge clk) !rst_n |-> !busy && !rsp_valid)
        else stop_run("busy or rsp_valid high while reset is held");
    rsp_needs_cmd_a: assert property (@(posedge clk) disable iff (!rst_n) rsp_valid |-> pending)
        else stop_run("rsp_valid rose with no command outstanding");
    one_in_flight_a: assert property (@(posedge clk) disable iff (!rst_n) accept |-> !pending)
        else stop_run("second command accepted before the first response");

    // busy window runs from the cycle after acceptance to the cycle after rsp_valid
    busy_set_a: assert property (@(posedge clk) disable iff (!rst_n) accept |=> busy)
        else stop_run("busy did not rise after acceptance");
    busy_idle_a: assert property (@(posedge clk) disable iff (!rst_n) !busy && !accept |=> !busy)
        else stop_run("busy rose without an accepted command");
    busy_hold_a: assert property (@(posedge clk) disable iff (!rst_n) busy && !rsp_valid |=> busy)
        else stop_run("busy dropped before the response");
    busy_drop_a: assert property (@(posedge clk) disable iff (!rst_n) rsp_valid |=> !busy)
        else stop_run("busy still high in the cycle after rsp_valid");

    rsp_tag_a: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> rsp.tag == exp_cur.rsp.tag)
        else value_mismatch("rsp.tag", exp_cur.rsp.tag, $sampled(rsp.tag));
    rsp_rdata_a: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> rsp.rdata == exp_cur.rsp.rdata)
        else value_mismatch("rsp.rdata", exp_cur.rsp.rdata, $sampled(rsp.rdata));
    rsp_err_a: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> rsp.err == exp_cur.rsp.err)
        else value_mismatch("rsp.err", exp_cur.rsp.err, $sampled(rsp.err));
    rsp_latency_a: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> since == int'(exp_cur.lat))
        else value_mismatch("rsp_valid latency", exp_cur.lat, $sampled(since));

    initial begin
        mem_pkg::cmd_t c;
        int unsigned   code;
        void'($urandom(32'hb0eb7103));  // seed once
        clk       = 1'b0;
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        cyc       = 0;
        for (int i = 0; i < mem_pkg::depth; i++) begin
            model_mem[i] = '0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        // ram has no reset so every word gets a full-mask write first
        for (int i = 0; i < n_init; i++) begin
            c         = '0;
            c.op      = mem_pkg::op_write;
            c.addr    = mem_pkg::addr_t'(i);
            c.operand = $urandom();
            c.mask    = '1;
            c.tag     = mem_pkg::tag_t'(i);
            send_cmd(c);
        end
        for (int i = 0; i < n_rand; i++) begin
            code      = $urandom_range(0, 9);  // 8 and 9 fold onto read
            c.op      = mem_pkg::op_e'(code > 7 ? 3'd0 : code[2:0]);
            c.addr    = mem_pkg::addr_t'($urandom_range(0, 7));  // small window so words repeat
            c.operand = $urandom();
            c.mask    = $urandom();
            c.tag     = mem_pkg::tag_t'($urandom());
            send_cmd(c);
        end
        if (rsp_count == n_init + n_rand && exp_q.size() == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            stop_run($sformatf("got %0d responses for %0d commands", rsp_count,
                               n_init + n_rand));
        end
    end

endmodule

`default_nettype wire

//--- tb.f
hdl/mem_pkg.sv
hdl/spram.sv
hdl/cmd_decode.sv
hdl/mem_execute.sv
hdl/rsp_result.sv
hdl/mem_unit_top.sv
sim/tb_mem_unit.sv
